// File: xgbaser_cfg.svh
`ifndef XGBASER_CFG_SVH
`define XGBASER_CFG_SVH

// channel count and synchronizer stages
`define XG_NUM_CH      4
`define XG_SYNC_DEPTH  2

// reset phase lengths in mgmt_clk cycles
`define XG_T_PLL_PD    16
`define XG_T_TX_DIG    4
`define XG_T_RX_ANA    4
`define XG_T_RX_DIG    32

// common region
`define XG_ADDR_PLL_LOCK    8'h10
`define XG_ADDR_CDR_LOCK    8'h11
`define XG_ADDR_RESET_CTRL  8'h12
`define XG_ADDR_LOOPBACK    8'h14
`define XG_ADDR_LOCKTOREF   8'h15
`define XG_ADDR_LOCKTODATA  8'h16

// pcs region (bit 7 set)
`define XG_ADDR_CH_SEL      8'h80
`define XG_ADDR_PCS_STATUS  8'h81

`endif

// File: xgbaser_pkg.sv
`include "xgbaser_cfg.svh"

package xgbaser_pkg;

  // management bus
  typedef logic [7:0]  mgmt_addr_t;   // word address
  typedef logic [31:0] mgmt_data_t;
  typedef logic [6:0]  reg_idx_t;     // index inside one region

  // per-channel vectors
  typedef logic [`XG_NUM_CH-1:0] ch_mask_t;
  typedef logic [1:0]            ch_sel_t;

  // pcs counters, one field per channel
  typedef logic [5:0] ber_cnt_t;
  typedef logic [7:0] errblk_cnt_t;
  typedef logic [`XG_NUM_CH*6-1:0] ber_cnt_bus_t;
  typedef logic [`XG_NUM_CH*8-1:0] errblk_cnt_bus_t;

  typedef enum logic [2:0] {
    ST_PLL_PD,
    ST_WAIT_PLL,
    ST_TX_RST,
    ST_RX_ANA,
    ST_WAIT_CDR,
    ST_RX_DIG,
    ST_READY
  } rst_state_t;

endpackage

// File: mgmt_decode.sv
module mgmt_decode (
  input  logic                    i_mgmt_clk,
  input  logic                    embedded_reset,
  input  logic                    i_mgmt_read,
  input  logic                    i_mgmt_write,
  input  xgbaser_pkg::mgmt_addr_t i_mgmt_address,
  input  xgbaser_pkg::mgmt_data_t i_mgmt_writedata,
  output logic                    o_mgmt_waitrequest,
  output logic                    o_rd_en,
  output logic                    o_wr_en,
  output logic                    o_pcs_sel,
  output xgbaser_pkg::reg_idx_t   o_reg_idx,
  output xgbaser_pkg::mgmt_data_t o_wdata
);

  logic wait_q;  // set in the second cycle of a read

  //////////////////////////////
  // read wait state
  //////////////////////////////

  // first read cycle sets the flop, second one clears it again
  always_ff @(posedge i_mgmt_clk) begin
    if (embedded_reset) begin
      wait_q <= 1'b0;
    end else begin
      wait_q <= i_mgmt_read & ~wait_q;
    end
  end

  assign o_mgmt_waitrequest = i_mgmt_read & ~wait_q;  // stall one cycle
  assign o_rd_en            = i_mgmt_read & wait_q;   // data phase

  //////////////////////////////
  // address split and write path
  //////////////////////////////

  assign o_pcs_sel = i_mgmt_address[7];    // upper half is pcs region
  assign o_reg_idx = i_mgmt_address[6:0];

  // writes are never stalled
  assign o_wr_en = i_mgmt_write;
  assign o_wdata = i_mgmt_writedata;

endmodule

// File: reset_sequencer.sv
`include "xgbaser_cfg.svh"

module reset_sequencer (
  input  logic                  i_mgmt_clk,
  input  logic                  embedded_reset,
  input  logic                  i_tx_rst_req,
  input  logic                  i_rx_rst_req,
  input  xgbaser_pkg::ch_mask_t i_pll_locked,
  input  xgbaser_pkg::ch_mask_t i_rx_is_lockedtodata,
  output logic                  o_pll_powerdown,
  output logic                  o_tx_ready,
  output logic                  o_rx_ready,
  output xgbaser_pkg::ch_mask_t o_tx_digitalreset,
  output xgbaser_pkg::ch_mask_t o_rx_analogreset,
  output xgbaser_pkg::ch_mask_t o_rx_digitalreset
);
  import xgbaser_pkg::*;

  localparam int CNT_W = 6;

  rst_state_t       state_q;
  rst_state_t       state_d;
  logic [CNT_W-1:0] cnt_q;
  logic             restart;     // re-enter the current phase
  logic             pll_all;
  logic             cdr_all;
  logic             phase_done;
  logic             rx_up_q;     // rx side finished its last sequence
  logic             tx_rst;
  logic             rx_ana;

  // counter load value, phase length minus one
  function automatic logic [CNT_W-1:0] phase_len(input rst_state_t st);
    logic [CNT_W-1:0] len;
    case (st)
      ST_PLL_PD: len = CNT_W'(`XG_T_PLL_PD - 1);
      ST_TX_RST: len = CNT_W'(`XG_T_TX_DIG - 1);
      ST_RX_ANA: len = CNT_W'(`XG_T_RX_ANA - 1);
      ST_RX_DIG: len = CNT_W'(`XG_T_RX_DIG - 1);
      default:   len = '0;  // wait states are not timed
    endcase
    return len;
  endfunction

  assign pll_all    = &i_pll_locked;
  assign cdr_all    = &i_rx_is_lockedtodata;  // shared rx reset waits for every lane
  assign phase_done = (cnt_q == '0);

  //////////////////////////////
  // next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    restart = 1'b0;
    case (state_q)
      ST_PLL_PD:   if (phase_done) state_d = ST_WAIT_PLL;
      ST_WAIT_PLL: if (pll_all) state_d = ST_TX_RST;
      ST_TX_RST:   if (phase_done) state_d = rx_up_q ? ST_READY : ST_RX_ANA;
      ST_RX_ANA:   if (phase_done) state_d = ST_WAIT_CDR;
      ST_WAIT_CDR: if (cdr_all) state_d = ST_RX_DIG;
      ST_RX_DIG:   if (phase_done) state_d = ST_READY;
      default:     state_d = state_q;
    endcase

    // lock loss first, then the register requests
    if (state_q != ST_PLL_PD && state_q != ST_WAIT_PLL) begin
      if (!pll_all) begin
        state_d = ST_WAIT_PLL;
      end else if (!cdr_all && (state_q == ST_RX_DIG || state_q == ST_READY)) begin
        state_d = ST_WAIT_CDR;
      end else if (i_tx_rst_req) begin
        state_d = ST_TX_RST;
        restart = 1'b1;
      end else if (i_rx_rst_req && (state_q == ST_RX_DIG || state_q == ST_READY)) begin
        state_d = ST_RX_DIG;
        restart = 1'b1;
      end
    end
  end

  //////////////////////////////
  // state, phase timer, rx flag
  //////////////////////////////

  always_ff @(posedge i_mgmt_clk) begin
    if (embedded_reset) begin
      state_q <= ST_PLL_PD;
      cnt_q   <= phase_len(ST_PLL_PD);
      rx_up_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (restart || state_d != state_q) begin
        cnt_q <= phase_len(state_d);  // load on every phase entry
      end else if (!phase_done) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if (!pll_all || !cdr_all || i_rx_rst_req) begin
        rx_up_q <= 1'b0;
      end else if (state_q == ST_RX_DIG && state_d == ST_READY) begin
        rx_up_q <= 1'b1;
      end
    end
  end

  // tx stays in reset until its digital phase has run
  assign tx_rst = (state_q == ST_PLL_PD) || (state_q == ST_WAIT_PLL) || (state_q == ST_TX_RST);
  assign rx_ana = (state_q == ST_PLL_PD) || (state_q == ST_WAIT_PLL) ||
                  (state_q == ST_RX_ANA) || (state_q == ST_TX_RST && !rx_up_q);

  assign o_pll_powerdown   = (state_q == ST_PLL_PD);
  assign o_tx_ready        = ~tx_rst;
  assign o_rx_ready        = rx_up_q;
  assign o_tx_digitalreset = {`XG_NUM_CH{tx_rst}};
  assign o_rx_analogreset  = {`XG_NUM_CH{rx_ana}};
  assign o_rx_digitalreset = {`XG_NUM_CH{~rx_up_q}};

endmodule

// File: csr_regs.sv
`include "xgbaser_cfg.svh"

module csr_regs (
  input  logic                         i_mgmt_clk,
  input  logic                         embedded_reset,
  input  logic                         i_rd_en,
  input  logic                         i_wr_en,
  input  logic                         i_pcs_sel,
  input  logic                         i_tx_ready,
  input  logic                         i_rx_ready,
  input  xgbaser_pkg::reg_idx_t        i_reg_idx,
  input  xgbaser_pkg::mgmt_data_t      i_wdata,
  input  xgbaser_pkg::ch_mask_t        i_pll_locked,
  input  xgbaser_pkg::ch_mask_t        i_rx_is_lockedtodata,
  input  xgbaser_pkg::ch_mask_t        i_block_lock,
  input  xgbaser_pkg::ch_mask_t        i_hi_ber,
  input  xgbaser_pkg::ch_mask_t        i_rx_data_ready,
  input  xgbaser_pkg::ber_cnt_bus_t    i_ber_cnt,
  input  xgbaser_pkg::errblk_cnt_bus_t i_errblk_cnt,
  output xgbaser_pkg::mgmt_data_t      o_mgmt_readdata,
  output logic                         o_tx_rst_req,
  output logic                         o_rx_rst_req,
  output xgbaser_pkg::ch_mask_t        o_loopback,
  output xgbaser_pkg::ch_mask_t        o_rx_set_locktoref,
  output xgbaser_pkg::ch_mask_t        o_rx_set_locktodata,
  output xgbaser_pkg::ch_mask_t        o_clr_errblk_cnt,
  output xgbaser_pkg::ch_mask_t        o_clr_ber_cnt
);
  import xgbaser_pkg::*;

  mgmt_addr_t  addr;         // region bit and index joined again
  ch_sel_t     ch_sel_q;
  ch_mask_t    sel_mask;     // one-hot of the selected channel
  ch_mask_t    loopback_q;
  ch_mask_t    locktoref_q;
  ch_mask_t    locktodata_q;
  ber_cnt_t    sel_ber;
  errblk_cnt_t sel_errblk;
  mgmt_data_t  rdata_d;
  mgmt_data_t  rdata_q;
  logic        wr_reset_ctrl;
  logic        wr_pcs_status;

  assign addr          = {i_pcs_sel, i_reg_idx};
  assign wr_reset_ctrl = i_wr_en && (addr == `XG_ADDR_RESET_CTRL);
  assign wr_pcs_status = i_wr_en && (addr == `XG_ADDR_PCS_STATUS);
  assign sel_mask      = ch_mask_t'(1) << ch_sel_q;

  //////////////////////////////
  // read/write control registers
  //////////////////////////////

  always_ff @(posedge i_mgmt_clk) begin
    if (embedded_reset) begin
      ch_sel_q     <= '0;
      loopback_q   <= '0;
      locktoref_q  <= '0;
      locktodata_q <= '0;
    end else if (i_wr_en) begin
      case (addr)
        `XG_ADDR_LOOPBACK:   loopback_q   <= i_wdata[`XG_NUM_CH-1:0];
        `XG_ADDR_LOCKTOREF:  locktoref_q  <= i_wdata[`XG_NUM_CH-1:0];
        `XG_ADDR_LOCKTODATA: locktodata_q <= i_wdata[`XG_NUM_CH-1:0];
        `XG_ADDR_CH_SEL:     ch_sel_q     <= i_wdata[1:0];
        default: ;
      endcase
    end
  end

  // self-clearing request and clear strobes
  always_ff @(posedge i_mgmt_clk) begin
    if (embedded_reset) begin
      o_tx_rst_req     <= 1'b0;
      o_rx_rst_req     <= 1'b0;
      o_clr_errblk_cnt <= '0;
      o_clr_ber_cnt    <= '0;
    end else begin
      o_tx_rst_req     <= wr_reset_ctrl & i_wdata[0];
      o_rx_rst_req     <= wr_reset_ctrl & i_wdata[1];
      o_clr_errblk_cnt <= (wr_pcs_status && i_wdata[2]) ? sel_mask : '0;
      o_clr_ber_cnt    <= (wr_pcs_status && i_wdata[3]) ? sel_mask : '0;
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////

  assign sel_ber    = i_ber_cnt[ch_sel_q * $bits(ber_cnt_t) +: $bits(ber_cnt_t)];
  assign sel_errblk = i_errblk_cnt[ch_sel_q * $bits(errblk_cnt_t) +: $bits(errblk_cnt_t)];

  always_comb begin
    rdata_d = '0;  // unmapped reads return zero
    case (addr)
      `XG_ADDR_PLL_LOCK:   rdata_d = mgmt_data_t'(i_pll_locked);
      `XG_ADDR_CDR_LOCK:   rdata_d = mgmt_data_t'(i_rx_is_lockedtodata);
      `XG_ADDR_RESET_CTRL: rdata_d[1:0] = {i_rx_ready, i_tx_ready};
      `XG_ADDR_LOOPBACK:   rdata_d = mgmt_data_t'(loopback_q);
      `XG_ADDR_LOCKTOREF:  rdata_d = mgmt_data_t'(locktoref_q);
      `XG_ADDR_LOCKTODATA: rdata_d = mgmt_data_t'(locktodata_q);
      `XG_ADDR_CH_SEL:     rdata_d = mgmt_data_t'(ch_sel_q);
      `XG_ADDR_PCS_STATUS: begin
        rdata_d[0]     = i_block_lock[ch_sel_q];
        rdata_d[1]     = i_hi_ber[ch_sel_q];
        rdata_d[2]     = i_rx_data_ready[ch_sel_q];
        rdata_d[13:8]  = sel_ber;
        rdata_d[23:16] = sel_errblk;
      end
      default: ;
    endcase
  end

  // sampled in the wait cycle, shown in the data cycle
  always_ff @(posedge i_mgmt_clk) begin
    rdata_q <= rdata_d;
  end

  assign o_mgmt_readdata     = i_rd_en ? rdata_q : '0;
  assign o_loopback          = loopback_q;
  assign o_rx_set_locktoref  = locktoref_q;
  assign o_rx_set_locktodata = locktodata_q;

endmodule

// File: status_sync.sv
`include "xgbaser_cfg.svh"

module status_sync (
  input  logic                  i_mgmt_clk,
  input  xgbaser_pkg::ch_mask_t i_block_lock,
  input  xgbaser_pkg::ch_mask_t i_hi_ber,
  input  xgbaser_pkg::ch_mask_t i_rx_data_ready,
  output xgbaser_pkg::ch_mask_t o_block_lock,
  output xgbaser_pkg::ch_mask_t o_hi_ber,
  output xgbaser_pkg::ch_mask_t o_rx_data_ready
);

  // all three flag vectors share one chain
  localparam int FLAG_W = 3 * `XG_NUM_CH;

  logic [FLAG_W-1:0] sync_q [`XG_SYNC_DEPTH];  // stage 0 faces the pcs domain

  always_ff @(posedge i_mgmt_clk) begin
    sync_q[0] <= {i_rx_data_ready, i_hi_ber, i_block_lock};
    for (int s = 1; s < `XG_SYNC_DEPTH; s++) begin
      sync_q[s] <= sync_q[s-1];
    end
  end

  // last stage is the settled copy
  assign {o_rx_data_ready, o_hi_ber, o_block_lock} = sync_q[`XG_SYNC_DEPTH-1];

endmodule

// File: xgbaser_mgmt_top.sv
module xgbaser_mgmt_top (
  input  logic                         i_mgmt_clk,
  input  logic                         embedded_reset,
  input  logic                         i_mgmt_read,
  input  logic                         i_mgmt_write,
  input  xgbaser_pkg::mgmt_addr_t      i_mgmt_address,
  input  xgbaser_pkg::mgmt_data_t      i_mgmt_writedata,
  output xgbaser_pkg::mgmt_data_t      o_mgmt_readdata,
  output logic                         o_mgmt_waitrequest,
  input  xgbaser_pkg::ch_mask_t        i_pll_locked,
  input  xgbaser_pkg::ch_mask_t        i_rx_is_lockedtodata,
  input  xgbaser_pkg::ch_mask_t        i_block_lock,
  input  xgbaser_pkg::ch_mask_t        i_hi_ber,
  input  xgbaser_pkg::ch_mask_t        i_rx_data_ready,
  input  xgbaser_pkg::ber_cnt_bus_t    i_ber_cnt,
  input  xgbaser_pkg::errblk_cnt_bus_t i_errblk_cnt,
  output xgbaser_pkg::ch_mask_t        o_block_lock,
  output xgbaser_pkg::ch_mask_t        o_hi_ber,
  output xgbaser_pkg::ch_mask_t        o_rx_data_ready,
  output logic                         o_tx_ready,
  output logic                         o_rx_ready,
  output logic                         o_pll_powerdown,
  output xgbaser_pkg::ch_mask_t        o_tx_digitalreset,
  output xgbaser_pkg::ch_mask_t        o_rx_analogreset,
  output xgbaser_pkg::ch_mask_t        o_rx_digitalreset,
  output xgbaser_pkg::ch_mask_t        o_loopback,
  output xgbaser_pkg::ch_mask_t        o_rx_set_locktoref,
  output xgbaser_pkg::ch_mask_t        o_rx_set_locktodata,
  output xgbaser_pkg::ch_mask_t        o_clr_errblk_cnt,
  output xgbaser_pkg::ch_mask_t        o_clr_ber_cnt
);
  import xgbaser_pkg::*;

  logic       rd_en;
  logic       wr_en;
  logic       pcs_sel;
  reg_idx_t   reg_idx;
  mgmt_data_t wdata;
  logic       tx_rst_req;   // pulses from RESET_CTRL
  logic       rx_rst_req;

  mgmt_decode mgmt_decode_inst (
    .i_mgmt_clk         (i_mgmt_clk),
    .embedded_reset     (embedded_reset),
    .i_mgmt_read        (i_mgmt_read),
    .i_mgmt_write       (i_mgmt_write),
    .i_mgmt_address     (i_mgmt_address),
    .i_mgmt_writedata   (i_mgmt_writedata),
    .o_mgmt_waitrequest (o_mgmt_waitrequest),
    .o_rd_en            (rd_en),
    .o_wr_en            (wr_en),
    .o_pcs_sel          (pcs_sel),
    .o_reg_idx          (reg_idx),
    .o_wdata            (wdata)
  );

  reset_sequencer reset_sequencer_inst (
    .i_mgmt_clk           (i_mgmt_clk),
    .embedded_reset       (embedded_reset),
    .i_tx_rst_req         (tx_rst_req),
    .i_rx_rst_req         (rx_rst_req),
    .i_pll_locked         (i_pll_locked),
    .i_rx_is_lockedtodata (i_rx_is_lockedtodata),
    .o_pll_powerdown      (o_pll_powerdown),
    .o_tx_ready           (o_tx_ready),
    .o_rx_ready           (o_rx_ready),
    .o_tx_digitalreset    (o_tx_digitalreset),
    .o_rx_analogreset     (o_rx_analogreset),
    .o_rx_digitalreset    (o_rx_digitalreset)
  );

  // csr sees the synchronized flags, same as the pins
  csr_regs csr_regs_inst (
    .i_mgmt_clk           (i_mgmt_clk),
    .embedded_reset       (embedded_reset),
    .i_rd_en              (rd_en),
    .i_wr_en              (wr_en),
    .i_pcs_sel            (pcs_sel),
    .i_tx_ready           (o_tx_ready),
    .i_rx_ready           (o_rx_ready),
    .i_reg_idx            (reg_idx),
    .i_wdata              (wdata),
    .i_pll_locked         (i_pll_locked),
    .i_rx_is_lockedtodata (i_rx_is_lockedtodata),
    .i_block_lock         (o_block_lock),
    .i_hi_ber             (o_hi_ber),
    .i_rx_data_ready      (o_rx_data_ready),
    .i_ber_cnt            (i_ber_cnt),
    .i_errblk_cnt         (i_errblk_cnt),
    .o_mgmt_readdata      (o_mgmt_readdata),
    .o_tx_rst_req         (tx_rst_req),
    .o_rx_rst_req         (rx_rst_req),
    .o_loopback           (o_loopback),
    .o_rx_set_locktoref   (o_rx_set_locktoref),
    .o_rx_set_locktodata  (o_rx_set_locktodata),
    .o_clr_errblk_cnt     (o_clr_errblk_cnt),
    .o_clr_ber_cnt        (o_clr_ber_cnt)
  );

  status_sync status_sync_inst (
    .i_mgmt_clk      (i_mgmt_clk),
    .i_block_lock    (i_block_lock),
    .i_hi_ber        (i_hi_ber),
    .i_rx_data_ready (i_rx_data_ready),
    .o_block_lock    (o_block_lock),
    .o_hi_ber        (o_hi_ber),
    .o_rx_data_ready (o_rx_data_ready)
  );

endmodule

// File: xgbaser_asserts.sv
module xgbaser_asserts (
  input logic                    i_mgmt_clk,
  input logic                    embedded_reset,
  input logic                    i_mgmt_read,
  input logic                    i_waitrequest,
  input xgbaser_pkg::mgmt_data_t i_readdata,
  input logic                    i_pll_powerdown,
  input logic                    i_tx_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  // second read cycle always releases the bus
  a_wait_one_cycle: assert property (@(posedge i_mgmt_clk) disable iff (embedded_reset)
    (i_mgmt_read && i_waitrequest) |=> !i_waitrequest)
    else $error("waitrequest held for more than one cycle");

  a_rdata_idle_zero: assert property (@(posedge i_mgmt_clk) disable iff (embedded_reset)
    !(i_mgmt_read && !i_waitrequest) |-> (i_readdata == '0))
    else $error("readdata nonzero outside a data cycle");

  a_tx_ready_pdn: assert property (@(posedge i_mgmt_clk) disable iff (embedded_reset)
    !(i_tx_ready && i_pll_powerdown))
    else $error("tx_ready high with plls powered down");

endmodule

// bus and reset outputs seen at the top level
bind xgbaser_mgmt_top xgbaser_asserts xgbaser_asserts_inst (
  .i_mgmt_clk      (i_mgmt_clk),
  .embedded_reset  (embedded_reset),
  .i_mgmt_read     (i_mgmt_read),
  .i_waitrequest   (o_mgmt_waitrequest),
  .i_readdata      (o_mgmt_readdata),
  .i_pll_powerdown (o_pll_powerdown),
  .i_tx_ready      (o_tx_ready)
);

// File: tb_xgbaser_mgmt.sv
`include "xgbaser_cfg.svh"

module tb_xgbaser_mgmt;
  timeunit 1ns;
  timeprecision 1ps;
  import xgbaser_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int PHASE_SUM  = `XG_T_PLL_PD + `XG_T_TX_DIG + `XG_T_RX_ANA + `XG_T_RX_DIG;
  localparam int WATCHDOG_CYCLES = PHASE_SUM * 10 + 2000;

  logic            mgmt_clk;
  logic            embedded_reset;
  logic            i_mgmt_read;
  logic            i_mgmt_write;
  mgmt_addr_t      i_mgmt_address;
  mgmt_data_t      i_mgmt_writedata;
  mgmt_data_t      o_mgmt_readdata;
  logic            o_mgmt_waitrequest;
  ch_mask_t        i_pll_locked;
  ch_mask_t        i_rx_is_lockedtodata;
  ch_mask_t        i_block_lock;
  ch_mask_t        i_hi_ber;
  ch_mask_t        i_rx_data_ready;
  ber_cnt_bus_t    i_ber_cnt;
  errblk_cnt_bus_t i_errblk_cnt;
  ch_mask_t        o_block_lock;
  ch_mask_t        o_hi_ber;
  ch_mask_t        o_rx_data_ready;
  logic            o_tx_ready;
  logic            o_rx_ready;
  logic            o_pll_powerdown;
  ch_mask_t        o_tx_digitalreset;
  ch_mask_t        o_rx_analogreset;
  ch_mask_t        o_rx_digitalreset;
  ch_mask_t        o_loopback;
  ch_mask_t        o_rx_set_locktoref;
  ch_mask_t        o_rx_set_locktodata;
  ch_mask_t        o_clr_errblk_cnt;
  ch_mask_t        o_clr_ber_cnt;
  int              err_value;  // wrong values seen
  int              err_other;  // stalls, timeouts

  xgbaser_mgmt_top xgbaser_mgmt_top_inst (
    .i_mgmt_clk (mgmt_clk),
    .*
  );

  initial mgmt_clk = 1'b0;
  always #(CLK_PERIOD / 2) mgmt_clk = ~mgmt_clk;

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_data(input string name, input mgmt_data_t exp, input mgmt_data_t act);
    if (act !== exp) begin
      err_value++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_mask(input string name, input ch_mask_t exp, input ch_mask_t act);
    if (act !== exp) begin
      err_value++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_value++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic note_failure(input string what);
    err_other++;
    $display("%0t %s", $time, what);
  endtask

  //////////////////////////////
  // bus tasks
  //////////////////////////////

  task automatic bus_write(input mgmt_addr_t addr, input mgmt_data_t data);
    @(posedge mgmt_clk);
    i_mgmt_write     <= 1'b1;
    i_mgmt_address   <= addr;
    i_mgmt_writedata <= data;
    @(posedge mgmt_clk);
    i_mgmt_write <= 1'b0;  // single-cycle strobe
  endtask

  task automatic bus_read(input mgmt_addr_t addr, output mgmt_data_t data);
    int waits;
    waits = 0;
    @(posedge mgmt_clk);
    i_mgmt_read    <= 1'b1;
    i_mgmt_address <= addr;
    @(negedge mgmt_clk);
    while (o_mgmt_waitrequest && waits < 8) begin
      waits++;
      @(negedge mgmt_clk);
    end
    if (o_mgmt_waitrequest) begin
      note_failure($sformatf("read of 0x%h never released by waitrequest", addr));
    end else if (waits != 1) begin
      note_failure($sformatf("read of 0x%h stalled %0d cycles, not one", addr, waits));
    end
    data = o_mgmt_readdata;  // valid while waitrequest is low
    @(posedge mgmt_clk);
    i_mgmt_read <= 1'b0;
  endtask

  // counts cycles until the chosen ready flag is high
  task automatic cycles_until_ready(input logic rx_side, input int limit, output int cycles);
    cycles = 0;
    @(negedge mgmt_clk);
    while (!(rx_side ? o_rx_ready : o_tx_ready) && cycles < limit) begin
      cycles++;
      @(negedge mgmt_clk);
    end
    if (!(rx_side ? o_rx_ready : o_tx_ready)) begin
      note_failure($sformatf("%s did not rise within %0d cycles",
                             rx_side ? "rx_ready" : "tx_ready", limit));
    end
  endtask

  function automatic ch_mask_t ctrl_out(input mgmt_addr_t addr);
    case (addr)
      `XG_ADDR_LOOPBACK:  return o_loopback;
      `XG_ADDR_LOCKTOREF: return o_rx_set_locktoref;
      default:            return o_rx_set_locktodata;
    endcase
  endfunction

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_bringup();
    int         cycles;
    mgmt_data_t rd;
    @(negedge mgmt_clk);  // still inside reset
    check_bit("o_pll_powerdown", 1'b1, o_pll_powerdown);
    check_bit("o_tx_ready", 1'b0, o_tx_ready);
    check_bit("o_rx_ready", 1'b0, o_rx_ready);
    check_bit("o_mgmt_waitrequest", 1'b0, o_mgmt_waitrequest);
    check_data("o_mgmt_readdata", '0, o_mgmt_readdata);
    check_mask("o_tx_digitalreset", '1, o_tx_digitalreset);
    check_mask("o_rx_analogreset", '1, o_rx_analogreset);
    check_mask("o_rx_digitalreset", '1, o_rx_digitalreset);
    check_mask("o_loopback", '0, o_loopback);
    check_mask("o_rx_set_locktoref", '0, o_rx_set_locktoref);
    check_mask("o_rx_set_locktodata", '0, o_rx_set_locktodata);
    check_mask("o_clr_errblk_cnt", '0, o_clr_errblk_cnt);
    check_mask("o_clr_ber_cnt", '0, o_clr_ber_cnt);
    @(posedge mgmt_clk);
    embedded_reset <= 1'b0;
    cycles = 0;
    @(negedge mgmt_clk);
    while (o_pll_powerdown && cycles < 4 * `XG_T_PLL_PD) begin
      cycles++;
      @(negedge mgmt_clk);
    end
    check_data("pll_powerdown cycles", mgmt_data_t'(`XG_T_PLL_PD), mgmt_data_t'(cycles));
    // transceiver locks once the plls are powered
    @(posedge mgmt_clk);
    i_pll_locked         <= '1;
    i_rx_is_lockedtodata <= '1;
    cycles_until_ready(1'b0, PHASE_SUM, cycles);
    check_bit("o_rx_ready", 1'b0, o_rx_ready);  // tx comes up first
    cycles_until_ready(1'b1, PHASE_SUM, cycles);
    bus_read(`XG_ADDR_RESET_CTRL, rd);
    check_data("reset_ctrl", 32'h3, rd);
  endtask

  task automatic test_registers();
    mgmt_addr_t regs [3] = '{`XG_ADDR_LOOPBACK, `XG_ADDR_LOCKTOREF, `XG_ADDR_LOCKTODATA};
    ch_mask_t   mask;
    mgmt_data_t rd;
    for (int r = 0; r < 3; r++) begin
      mask = ch_mask_t'($urandom | 1);  // never the reset value
      bus_write(regs[r], mgmt_data_t'(mask));
      @(negedge mgmt_clk);
      check_mask($sformatf("output of reg 0x%h", regs[r]), mask, ctrl_out(regs[r]));
      bus_read(regs[r], rd);
      check_data($sformatf("readback of reg 0x%h", regs[r]), mgmt_data_t'(mask), rd);
    end
    bus_read(`XG_ADDR_PLL_LOCK, rd);
    check_data("pll_lock", mgmt_data_t'(i_pll_locked), rd);
    bus_read(8'h13, rd);  // hole in the common region
    check_data("unmapped 0x13", '0, rd);
    bus_read(8'h9f, rd);
    check_data("unmapped 0x9f", '0, rd);
  endtask

  task automatic test_status_sync();
    ch_mask_t        old_bl;
    ch_mask_t        old_hb;
    ch_mask_t        old_dr;
    ch_mask_t        new_bl;
    ch_mask_t        new_hb;
    ch_mask_t        new_dr;
    ber_cnt_t        ber_vals [`XG_NUM_CH];
    errblk_cnt_t     errblk_vals [`XG_NUM_CH];
    ber_cnt_bus_t    ber_bus;
    errblk_cnt_bus_t errblk_bus;
    mgmt_data_t      exp;
    mgmt_data_t      rd;
    old_bl = i_block_lock;
    old_hb = i_hi_ber;
    old_dr = i_rx_data_ready;
    new_bl = old_bl ^ ch_mask_t'($urandom | 1);  // bit 0 always toggles
    new_hb = old_hb ^ ch_mask_t'($urandom | 1);
    new_dr = old_dr ^ ch_mask_t'($urandom | 1);
    // channel 0 sits in the low field of each counter bus
    for (int ch = 0; ch < `XG_NUM_CH; ch++) begin
      ber_vals[ch]    = ber_cnt_t'($urandom);
      errblk_vals[ch] = errblk_cnt_t'($urandom);
      ber_bus[ch * $bits(ber_cnt_t) +: $bits(ber_cnt_t)]          = ber_vals[ch];
      errblk_bus[ch * $bits(errblk_cnt_t) +: $bits(errblk_cnt_t)] = errblk_vals[ch];
    end
    @(posedge mgmt_clk);
    i_block_lock    <= new_bl;
    i_hi_ber        <= new_hb;
    i_rx_data_ready <= new_dr;
    i_ber_cnt       <= ber_bus;
    i_errblk_cnt    <= errblk_bus;
    for (int k = 0; k <= `XG_SYNC_DEPTH; k++) begin
      @(negedge mgmt_clk);
      check_mask("o_block_lock", (k == `XG_SYNC_DEPTH) ? new_bl : old_bl, o_block_lock);
      check_mask("o_hi_ber", (k == `XG_SYNC_DEPTH) ? new_hb : old_hb, o_hi_ber);
      check_mask("o_rx_data_ready", (k == `XG_SYNC_DEPTH) ? new_dr : old_dr, o_rx_data_ready);
    end
    for (int ch = 0; ch < `XG_NUM_CH; ch++) begin
      bus_write(`XG_ADDR_CH_SEL, mgmt_data_t'(ch));
      exp        = '0;
      exp[0]     = new_bl[ch];
      exp[1]     = new_hb[ch];
      exp[2]     = new_dr[ch];
      exp[13:8]  = ber_vals[ch];
      exp[23:16] = errblk_vals[ch];
      bus_read(`XG_ADDR_PCS_STATUS, rd);
      check_data($sformatf("pcs_status ch%0d", ch), exp, rd);
    end
  endtask

  task automatic test_counter_clears();
    ch_sel_t  ch;
    ch_mask_t sel;
    ch  = ch_sel_t'($urandom);
    sel = ch_mask_t'(1) << ch;
    bus_write(`XG_ADDR_CH_SEL, mgmt_data_t'(ch));
    bus_write(`XG_ADDR_PCS_STATUS, 32'h0000_000c);  // both clears
    @(negedge mgmt_clk);
    check_mask("o_clr_errblk_cnt", sel, o_clr_errblk_cnt);
    check_mask("o_clr_ber_cnt", sel, o_clr_ber_cnt);
    @(negedge mgmt_clk);
    check_mask("o_clr_errblk_cnt", '0, o_clr_errblk_cnt);
    check_mask("o_clr_ber_cnt", '0, o_clr_ber_cnt);
    bus_write(`XG_ADDR_PCS_STATUS, 32'h0000_0004);
    @(negedge mgmt_clk);
    check_mask("o_clr_errblk_cnt", sel, o_clr_errblk_cnt);
    check_mask("o_clr_ber_cnt", '0, o_clr_ber_cnt);
    @(negedge mgmt_clk);
    check_mask("o_clr_errblk_cnt", '0, o_clr_errblk_cnt);
  endtask

  task automatic test_reset_requests();
    int         cycles;
    int         waits;
    ch_mask_t   lost;
    mgmt_data_t rd;
    bus_write(`XG_ADDR_RESET_CTRL, 32'h2);  // rx digital reset
    @(posedge mgmt_clk);
    cycles_until_ready(1'b1, `XG_T_RX_DIG * 4, cycles);
    check_data("rx_ready low cycles", mgmt_data_t'(`XG_T_RX_DIG), mgmt_data_t'(cycles));
    check_bit("o_tx_ready", 1'b1, o_tx_ready);
    // one pll drops out
    lost = ~(ch_mask_t'(1) << ($urandom % `XG_NUM_CH));
    @(posedge mgmt_clk);
    i_pll_locked <= lost;
    waits = 0;
    @(negedge mgmt_clk);
    while (o_tx_ready && waits < 8) begin
      waits++;
      @(negedge mgmt_clk);
    end
    if (o_tx_ready) begin
      note_failure("tx_ready stayed high after a pll lost lock");
    end
    check_bit("o_rx_ready", 1'b0, o_rx_ready);
    @(posedge mgmt_clk);
    i_pll_locked <= '1;
    cycles_until_ready(1'b0, PHASE_SUM * 4, cycles);
    if (cycles < `XG_T_TX_DIG || cycles > `XG_T_TX_DIG + 2) begin
      note_failure($sformatf("tx_ready came back after %0d cycles", cycles));
    end
    cycles_until_ready(1'b1, PHASE_SUM * 4, cycles);
    bus_read(`XG_ADDR_RESET_CTRL, rd);
    check_data("reset_ctrl", 32'h3, rd);
  endtask

  //////////////////////////////
  // run and verdict
  //////////////////////////////

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("errors: %0d value, %0d other", err_value, err_other + 1);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int seed;
    seed                 = $urandom(40);
    err_value            = 0;
    err_other            = 0;
    embedded_reset       = 1'b1;
    i_mgmt_read          = 1'b0;
    i_mgmt_write         = 1'b0;
    i_mgmt_address       = '0;
    i_mgmt_writedata     = '0;
    i_pll_locked         = '0;  // plls unlocked at power-up
    i_rx_is_lockedtodata = '0;
    i_block_lock         = '0;
    i_hi_ber             = '0;
    i_rx_data_ready      = '0;
    i_ber_cnt            = '0;
    i_errblk_cnt         = '0;
    repeat (9) @(posedge mgmt_clk);
    test_bringup();
    test_registers();
    test_status_sync();
    test_counter_clears();
    test_reset_requests();
    repeat (4) @(posedge mgmt_clk);
    $display("errors: %0d value, %0d other", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+.
xgbaser_pkg.sv
mgmt_decode.sv
reset_sequencer.sv
csr_regs.sv
status_sync.sv
xgbaser_mgmt_top.sv
xgbaser_asserts.sv
tb_xgbaser_mgmt.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the management testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_xgbaser_mgmt -f compile.f -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb | tee sim.log

grep -qx "TEST PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
